//--- Makefile
VERILATOR ?= verilator
TOP       ?= pe_row_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/bus_stage.sv
`timescale 1ns/1ps

module bus_stage import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bus_strobe,
    input  stream_t               bus_stream,
    input  tag_t                  bus_tag,
    input  psum_t                 bus_data,
    output logic [NUM_STREAM-1:0] cast_en,
    output tag_t                  cast_tag,
    output psum_t                 cast_data,
    output logic                  cfg_en,
    output tag_t                  cfg_col,
    output tag_t                  cfg_id
);

    // decoded next-cycle enables
    logic [NUM_STREAM-1:0] en_next;
    logic                  cfg_next;

    // stream code to one-hot enable, or an id write
    always_comb begin
        en_next  = '0;
        cfg_next = 1'b0;
        if (bus_strobe) begin
            case (bus_stream)
                STREAM_IFMAP: en_next[STREAM_IFMAP] = 1'b1;
                STREAM_FLTR:  en_next[STREAM_FLTR]  = 1'b1;
                STREAM_PSUM:  en_next[STREAM_PSUM]  = 1'b1;
                STREAM_CFG:   cfg_next              = 1'b1;
            endcase
        end
    end

    // enables last exactly one cycle per strobed item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cast_en <= '0;
            cfg_en  <= 1'b0;
        end else begin
            cast_en <= en_next;
            cfg_en  <= cfg_next;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (bus_strobe) begin
            cast_tag  <= bus_tag;
            cast_data <= bus_data;
            // cfg item: tag picks column, low data bits are the id
            cfg_col   <= bus_tag;
            cfg_id    <= bus_data[TAG_WIDTH-1:0];
        end
    end

endmodule

//--- rtl/caster.sv
`timescale 1ns/1ps

module caster import cnn_pkg::*; #(
    parameter type payload_t = data_t
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  tag_t                    tag,
    input  payload_t                data,
    input  tag_t [NUM_COL-1:0]      col_id,
    output logic [NUM_COL-1:0]      col_strobe,
    output payload_t                col_data,
    output logic                    hit
);

    // per-column tag match
    logic [NUM_COL-1:0] match;

    // all columns compared in parallel
    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            match[c] = (col_id[c] == tag);
        end
    end

    // strobe every matching column
    // hit tells the bus side the item landed somewhere
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_strobe <= '0;
            hit        <= 1'b0;
        end else begin
            if (en) begin
                col_strobe <= match;
                hit        <= |match;
            end else begin
                col_strobe <= '0;
                hit        <= 1'b0;
            end
        end
    end

    // shared payload, columns qualify it with their strobe
    // loaded even on a miss, nobody samples it then
    always_ff @(posedge clk) begin
        if (en) begin
            col_data <= data;
        end
    end

endmodule

//--- rtl/cnn_pkg.sv
package cnn_pkg;

    // ifmap and weight word width
    localparam int DATA_WIDTH = 16;
    // psum width, double the data word
    localparam int PSUM_WIDTH = 2 * DATA_WIDTH;

    // columns in one pe row
    localparam int NUM_COL = 4;
    // bits needed to index a column
    localparam int COL_IDX_WIDTH = (NUM_COL > 1) ? $clog2(NUM_COL) : 1;

    // tag and column id width
    localparam int TAG_WIDTH = 4;

    // ifmap, filter and psum streams
    localparam int NUM_STREAM = 3;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // stream code on the global bus
    // cfg writes a column id, tag selects the column
    typedef enum logic [1:0] {
        STREAM_IFMAP = 2'd0,
        STREAM_FLTR  = 2'd1,
        STREAM_PSUM  = 2'd2,
        STREAM_CFG   = 2'd3
    } stream_t;

endpackage

//--- rtl/multi_caster.sv
`timescale 1ns/1ps

module multi_caster import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_STREAM-1:0] cast_en,
    input  tag_t                  cast_tag,
    input  psum_t                 cast_data,
    input  logic                  cfg_en,
    input  tag_t                  cfg_col,
    input  tag_t                  cfg_id,
    output logic [NUM_COL-1:0]    ifmap_strobe,
    output logic [NUM_COL-1:0]    fltr_strobe,
    output logic [NUM_COL-1:0]    psum_strobe,
    output data_t                 ifmap_col_data,
    output data_t                 fltr_col_data,
    output psum_t                 psum_col_data,
    output logic [NUM_STREAM-1:0] cast_hit
);

    // column id table, shared by all three casters
    tag_t [NUM_COL-1:0] col_id;

    // ifmap and filter only carry the low word of the bus data
    data_t narrow_data;

    assign narrow_data = data_t'(cast_data[DATA_WIDTH-1:0]);

    // ids default to the column index
    // out-of-range column writes are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_COL; c++) begin
                col_id[c] <= tag_t'(c);
            end
        end else if (cfg_en && (int'(cfg_col) < NUM_COL)) begin
            col_id[cfg_col[COL_IDX_WIDTH-1:0]] <= cfg_id;
        end
    end

    // ifmap stream
    caster #(.payload_t(data_t)) ifmap_caster (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (cast_en[STREAM_IFMAP]),
        .tag        (cast_tag),
        .data       (narrow_data),
        .col_id     (col_id),
        .col_strobe (ifmap_strobe),
        .col_data   (ifmap_col_data),
        .hit        (cast_hit[STREAM_IFMAP])
    );

    // filter weights
    caster #(.payload_t(data_t)) fltr_caster (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (cast_en[STREAM_FLTR]),
        .tag        (cast_tag),
        .data       (narrow_data),
        .col_id     (col_id),
        .col_strobe (fltr_strobe),
        .col_data   (fltr_col_data),
        .hit        (cast_hit[STREAM_FLTR])
    );

    // psum preload, full width
    caster #(.payload_t(psum_t)) psum_caster (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (cast_en[STREAM_PSUM]),
        .tag        (cast_tag),
        .data       (cast_data),
        .col_id     (col_id),
        .col_strobe (psum_strobe),
        .col_data   (psum_col_data),
        .hit        (cast_hit[STREAM_PSUM])
    );

endmodule

//--- rtl/pe.sv
`timescale 1ns/1ps

module pe import cnn_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fltr_strobe,
    input  data_t fltr_data,
    input  logic  psum_strobe,
    input  psum_t psum_data,
    input  logic  ifmap_strobe,
    input  data_t ifmap_data,
    output logic  psum_valid,
    output psum_t psum_out
);

    // stationary weight
    data_t weight;
    // running partial sum
    psum_t acc;

    // mac datapath
    psum_t prod;
    psum_t acc_next;

    // signed 16x16 product, sum wraps at psum width
    always_comb begin
        prod     = psum_t'(weight) * psum_t'(ifmap_data);
        acc_next = acc + prod;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight <= '0;
        end else if (fltr_strobe) begin
            weight <= fltr_data;
        end
    end

    // one item per cycle upstream, so strobes never collide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (psum_strobe) begin
            acc <= psum_data;
        end else if (ifmap_strobe) begin
            acc <= acc_next;
        end
    end

    // valid follows the accumulate by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= ifmap_strobe;
        end
    end

    // accumulator already holds the fresh sum while valid is high
    assign psum_out = acc;

endmodule

//--- rtl/pe_row_top.sv
`timescale 1ns/1ps

module pe_row_top import cnn_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bus_strobe,
    input  stream_t               bus_stream,
    input  tag_t                  bus_tag,
    input  psum_t                 bus_data,
    output logic [NUM_COL-1:0]    psum_valid,
    output psum_t [NUM_COL-1:0]   psum_out,
    output logic [NUM_STREAM-1:0] cast_hit
);

    // bus stage to multicaster
    logic [NUM_STREAM-1:0] cast_en;
    tag_t                  cast_tag;
    psum_t                 cast_data;
    logic                  cfg_en;
    tag_t                  cfg_col;
    tag_t                  cfg_id;

    // multicaster to pe columns
    logic [NUM_COL-1:0] ifmap_strobe;
    logic [NUM_COL-1:0] fltr_strobe;
    logic [NUM_COL-1:0] psum_strobe;
    data_t              ifmap_col_data;
    data_t              fltr_col_data;
    psum_t              psum_col_data;

    bus_stage bus_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_strobe (bus_strobe),
        .bus_stream (bus_stream),
        .bus_tag    (bus_tag),
        .bus_data   (bus_data),
        .cast_en    (cast_en),
        .cast_tag   (cast_tag),
        .cast_data  (cast_data),
        .cfg_en     (cfg_en),
        .cfg_col    (cfg_col),
        .cfg_id     (cfg_id)
    );

    multi_caster multi_caster_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cast_en        (cast_en),
        .cast_tag       (cast_tag),
        .cast_data      (cast_data),
        .cfg_en         (cfg_en),
        .cfg_col        (cfg_col),
        .cfg_id         (cfg_id),
        .ifmap_strobe   (ifmap_strobe),
        .fltr_strobe    (fltr_strobe),
        .psum_strobe    (psum_strobe),
        .ifmap_col_data (ifmap_col_data),
        .fltr_col_data  (fltr_col_data),
        .psum_col_data  (psum_col_data),
        .cast_hit       (cast_hit)
    );

    // one pe per column, data buses shared, strobes per column
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        pe pe_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .fltr_strobe  (fltr_strobe[c]),
            .fltr_data    (fltr_col_data),
            .psum_strobe  (psum_strobe[c]),
            .psum_data    (psum_col_data),
            .ifmap_strobe (ifmap_strobe[c]),
            .ifmap_data   (ifmap_col_data),
            .psum_valid   (psum_valid[c]),
            .psum_out     (psum_out[c])
        );
    end

endmodule

//--- src.f
rtl/cnn_pkg.sv
rtl/bus_stage.sv
rtl/caster.sv
rtl/multi_caster.sv
rtl/pe.sv
rtl/pe_row_top.sv
tests/pe_row_tb.sv

//--- tests/pe_row_tb.sv
`timescale 1ns/1ps

module pe_row_tb import cnn_pkg::*; ();

    // hard stop for a stuck run, well above the stimulus length
    localparam int MAX_CYCLES = 400;
    localparam logic [15:0] LFSR_SEED = 16'd60712;

    logic                  clk;
    logic                  rst_n;
    logic                  bus_strobe;
    stream_t               bus_stream;
    tag_t                  bus_tag;
    psum_t                 bus_data;
    logic [NUM_COL-1:0]    psum_valid;
    psum_t [NUM_COL-1:0]   psum_out;
    logic [NUM_STREAM-1:0] cast_hit;

    // reference model state per column
    tag_t  model_id  [NUM_COL];
    data_t model_w   [NUM_COL];
    psum_t model_acc [NUM_COL];

    // expectations of the item currently on the bus
    logic [NUM_STREAM-1:0] ref_hit;
    logic [NUM_COL-1:0]    ref_valid;
    psum_t [NUM_COL-1:0]   ref_sum;

    // hits come out 2 cycles late, results 3
    logic [NUM_STREAM-1:0] hit_dl   [2];
    logic [NUM_COL-1:0]    valid_dl [3];
    psum_t [NUM_COL-1:0]   sum_dl   [3];

    logic [15:0] lfsr;
    int          cycles;
    int          n_checks;
    int          n_errors;

    pe_row_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_strobe (bus_strobe),
        .bus_stream (bus_stream),
        .bus_tag    (bus_tag),
        .bus_data   (bus_data),
        .psum_valid (psum_valid),
        .psum_out   (psum_out),
        .cast_hit   (cast_hit)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // mostly tags that hit, one that never does
    function automatic tag_t pick_tag();
        logic [31:0] sel;
        sel = rand_bits(2);
        case (sel[1:0])
            2'd0:    return 4'd7;
            2'd1:    return 4'd2;
            2'd2:    return 4'd7;
            default: return 4'd11;
        endcase
    endfunction

    // expected hit and per-column results for one bus cycle
    function automatic void ref_item(input logic strobe, input stream_t stream,
                                     input tag_t tag, input psum_t data);
        longint full;
        ref_hit   = '0;
        ref_valid = '0;
        ref_sum   = '0;
        if (strobe && stream == STREAM_CFG) begin
            // writes to a column that does not exist are dropped
            if (int'(tag) < NUM_COL) begin
                model_id[int'(tag)] = data[TAG_WIDTH-1:0];
            end
        end else if (strobe) begin
            for (int c = 0; c < NUM_COL; c++) begin
                if (model_id[c] == tag) begin
                    ref_hit[int'(stream)] = 1'b1;
                    case (stream)
                        STREAM_FLTR: model_w[c] = data_t'(data[DATA_WIDTH-1:0]);
                        STREAM_PSUM: model_acc[c] = data;
                        STREAM_IFMAP: begin
                            // full precision, then wrap to psum width
                            full = longint'(model_acc[c])
                                 + longint'(model_w[c]) * longint'(data_t'(data[DATA_WIDTH-1:0]));
                            model_acc[c] = psum_t'(full);
                            ref_valid[c] = 1'b1;
                            ref_sum[c]   = model_acc[c];
                        end
                        default: ;
                    endcase
                end
            end
        end
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // one bus item per call, held for one cycle
    task automatic send(input stream_t s, input tag_t t, input psum_t d);
        @(posedge clk);
        #1;
        bus_strobe = 1'b1;
        bus_stream = s;
        bus_tag    = t;
        bus_data   = d;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            bus_strobe = 1'b0;
        end
    endtask

    // negedge sampling, outputs and bus inputs are both settled here
    always @(negedge clk) begin
        check("cast_hit", 64'(cast_hit), 64'(hit_dl[1]));
        for (int c = 0; c < NUM_COL; c++) begin
            check($sformatf("psum_valid[%0d]", c), 64'(psum_valid[c]),
                  64'(valid_dl[2][c]));
            if (valid_dl[2][c]) begin
                check($sformatf("psum_out[%0d]", c), 64'(psum_out[c]),
                      64'(sum_dl[2][c]));
            end
        end
        hit_dl[1]   = hit_dl[0];
        valid_dl[2] = valid_dl[1];
        valid_dl[1] = valid_dl[0];
        sum_dl[2]   = sum_dl[1];
        sum_dl[1]   = sum_dl[0];
        // item that the next rising edge will take
        ref_item(bus_strobe, bus_stream, bus_tag, bus_data);
        hit_dl[0]   = ref_hit;
        valid_dl[0] = ref_valid;
        sum_dl[0]   = ref_sum;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks: %0d errors: %0d", n_checks, n_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        bus_strobe  = 1'b0;
        bus_stream  = STREAM_IFMAP;
        bus_tag     = '0;
        bus_data    = '0;
        lfsr        = LFSR_SEED;
        cycles      = 0;
        n_checks    = 0;
        n_errors    = 0;
        for (int c = 0; c < NUM_COL; c++) begin
            model_id[c]  = tag_t'(c);
            model_w[c]   = '0;
            model_acc[c] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            valid_dl[i] = '0;
            sum_dl[i]   = '0;
        end
        hit_dl[0] = '0;
        hit_dl[1] = '0;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet outputs after reset
        idle(6);

        // unicast to column 2
        send(STREAM_FLTR, 2, -7);
        send(STREAM_PSUM, 2, 1000);
        send(STREAM_IFMAP, 2, 13);
        idle(5);

        // own weight and psum per column, then ids 0, 1 and 3 become 7
        send(STREAM_FLTR, 0, 3);
        send(STREAM_FLTR, 1, -5);
        send(STREAM_FLTR, 3, 1200);
        send(STREAM_PSUM, 0, 100);
        send(STREAM_PSUM, 1, -2000);
        send(STREAM_PSUM, 3, 32'sh7fff_ff00);
        send(STREAM_CFG, 0, 7);
        send(STREAM_CFG, 1, 7);
        send(STREAM_CFG, 3, 7);
        send(STREAM_IFMAP, 7, 25);
        idle(5);

        // tags that match no column
        send(STREAM_IFMAP, 5, 99);
        send(STREAM_FLTR, 9, 44);
        send(STREAM_PSUM, 12, 555);
        // every column still has its old weight and psum
        send(STREAM_IFMAP, 2, 3);
        send(STREAM_IFMAP, 7, -2);
        idle(5);

        // large weights and psums so the burst wraps
        send(STREAM_FLTR, 2, 32767);
        send(STREAM_PSUM, 2, 32'sh7fff_0000);
        send(STREAM_FLTR, 7, -32768);
        send(STREAM_PSUM, 7, 32'sh8000_4000);
        for (int i = 0; i < 40; i++) begin
            send(STREAM_IFMAP, pick_tag(), psum_t'(data_t'(rand_bits(DATA_WIDTH))));
        end
        idle(5);

        // id rewrite takes effect on the very next item
        send(STREAM_CFG, 2, 9);
        send(STREAM_IFMAP, 9, 77);
        send(STREAM_IFMAP, 2, 5);
        // column 6 does not exist
        send(STREAM_CFG, 6, 3);
        send(STREAM_IFMAP, 3, 4);
        send(STREAM_IFMAP, 7, -300);
        idle(6);

        $display("checks: %0d errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
